// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_periph_top
FILELIST  := periph.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== periph.f ====
+incdir+.
periph_pkg.sv
wb_periph_bridge.sv
periph_gpio.sv
periph_pwm.sv
periph_io_mux.sv
periph_top.sv
tb_periph_top.sv

// ==== periph_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_gpio (
	input  wire                          wb_clk_i,
	input  wire                          rst_i,
	input  wire periph_pkg::periph_req_t req_i,
	input  wire [`PERIPH_IO_PADS-1:0]    gpio_input_i,
	output periph_pkg::periph_rsp_t      rsp_o,
	output logic [`PERIPH_IO_PADS-1:0]   gpio_output_o,
	output logic [`PERIPH_IO_PADS-1:0]   gpio_oe_o
);

	localparam int unsigned BYTES = `PERIPH_IO_PADS / 8;

	logic [`PERIPH_IO_PADS-1:0] out_q;
	logic [`PERIPH_IO_PADS-1:0] oe_q;
	logic [`PERIPH_IO_PADS-1:0] sync_q;
	logic [`PERIPH_IO_PADS-1:0] in_q;
	logic                       hit;
	logic [13:0]                offset;

	assign hit    = (req_i.address[23:16] == `PERIPH_ID_GPIO);
	assign offset = req_i.address[15:2];

	assign gpio_output_o = out_q;
	assign gpio_oe_o     = oe_q;

	always_comb begin
		rsp_o.request_output = hit & (req_i.we | req_i.oe);
		case (offset)
			`GPIO_REG_OUT: rsp_o.data_read = 32'(out_q);
			`GPIO_REG_OE:  rsp_o.data_read = 32'(oe_q);
			`GPIO_REG_IN:  rsp_o.data_read = 32'(in_q);
			default:       rsp_o.data_read = '0;
		endcase
	end

	// Input register is read only, writes to it fall through
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (hit && req_i.we) begin
			for (int b = 0; b < BYTES; b++) begin
				if (req_i.byte_select[b]) begin
					if (offset == `GPIO_REG_OUT)
						out_q[b*8 +: 8] <= req_i.data_write[b*8 +: 8];
					if (offset == `GPIO_REG_OE)
						oe_q[b*8 +: 8] <= req_i.data_write[b*8 +: 8];
				end
			end
		end
	end

	// Two-flop synchronizer for the pad inputs
	always_ff @(posedge wb_clk_i) begin
		sync_q <= gpio_input_i;
		in_q   <= sync_q;
	end

endmodule

`default_nettype wire

// ==== periph_io_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_io_mux (
	input  wire                              wb_clk_i,
	input  wire                              rst_i,
	input  wire periph_pkg::periph_req_t     req_i,
	input  wire [`PERIPH_IO_PADS-1:0]        gpio_output_i,
	input  wire [`PERIPH_IO_PADS-1:0]        gpio_oe_i,
	input  wire [`PERIPH_PWM_CHANNELS-1:0]   pwm_out_i,
	input  wire [`PERIPH_IO_PADS-1:0]        io_in_i,
	output periph_pkg::periph_rsp_t          rsp_o,
	output logic [`PERIPH_IO_PADS-1:0]       gpio_input_o,
	output logic [`PERIPH_IO_PADS-1:0]       io_out_o,
	output logic [`PERIPH_IO_PADS-1:0]       io_oeb_o
);

	localparam int unsigned BYTES = `PERIPH_IO_PADS / 8;

	logic [`PERIPH_IO_PADS-1:0] sel_q;   // 1 routes the pad to PWM
	logic                       hit;
	logic [13:0]                offset;

	assign hit    = (req_i.address[23:16] == `PERIPH_ID_IOMUX);
	assign offset = req_i.address[15:2];

	always_comb begin
		rsp_o.request_output = hit & (req_i.we | req_i.oe);
		rsp_o.data_read      = (offset == `IOMUX_REG_SEL) ? 32'(sel_q) : 32'd0;
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			sel_q <= '0;   // All pads start as GPIO
		end else if (hit && req_i.we && offset == `IOMUX_REG_SEL) begin
			for (int b = 0; b < BYTES; b++) begin
				if (req_i.byte_select[b])
					sel_q[b*8 +: 8] <= req_i.data_write[b*8 +: 8];
			end
		end
	end

	assign gpio_input_o = io_in_i;

	for (genvar p = 0; p < `PERIPH_IO_PADS; p++) begin : g_pad
		always_comb begin
			if (sel_q[p]) begin
				io_out_o[p] = pwm_out_i[p % `PERIPH_PWM_CHANNELS];
				io_oeb_o[p] = 1'b0;   // PWM pads always drive
			end else begin
				io_out_o[p] = gpio_output_i[p];
				io_oeb_o[p] = ~gpio_oe_i[p];
			end
		end
	end

endmodule

`default_nettype wire

// ==== periph_macros.svh ====
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

`define PERIPH_IO_PADS      16
`define PERIPH_PWM_CHANNELS 4

// Address bits 23:16 select the peripheral
`define PERIPH_ID_PWM   8'h02
`define PERIPH_ID_GPIO  8'h03
`define PERIPH_ID_IOMUX 8'h04

// Word offsets, compared against address bits 15:2
`define GPIO_REG_OUT    14'd0
`define GPIO_REG_OE     14'd1
`define GPIO_REG_IN     14'd2
`define PWM_REG_EN      14'd0
`define PWM_REG_PERIOD  14'd1
`define PWM_REG_DUTY0   14'd2  // Channel c at DUTY0 + c
`define IOMUX_REG_SEL   14'd0

`endif

// ==== periph_pkg.sv ====
`default_nettype none

package periph_pkg;

	// Broadcast from the bridge to every peripheral
	typedef struct packed {
		logic        we;
		logic        oe;           // Read strobe
		logic [23:0] address;      // ID in 23:16, word offset in 15:2
		logic [3:0]  byte_select;
		logic [31:0] data_write;
	} periph_req_t;

	// One peripheral's answer to the current request
	typedef struct packed {
		logic        request_output; // Peripheral claims the access
		logic [31:0] data_read;
	} periph_rsp_t;

endpackage

`default_nettype wire

// ==== periph_pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_pwm (
	input  wire                            wb_clk_i,
	input  wire                            rst_i,
	input  wire periph_pkg::periph_req_t   req_i,
	output periph_pkg::periph_rsp_t        rsp_o,
	output logic [`PERIPH_PWM_CHANNELS-1:0] pwm_out_o
);

	localparam int unsigned CH = `PERIPH_PWM_CHANNELS;

	logic [15:0]   period_q;
	logic [15:0]   duty_q [CH];
	logic [CH-1:0] en_q;
	logic [15:0]   cnt_q;
	logic          hit;
	logic          wr_en;
	logic [13:0]   offset;

	assign hit    = (req_i.address[23:16] == `PERIPH_ID_PWM);
	assign wr_en  = hit & req_i.we;
	assign offset = req_i.address[15:2];

	function automatic logic [15:0] merge16(input logic [15:0] old_v,
		input logic [31:0] wdata, input logic [3:0] sel);
		logic [15:0] v;
		v = old_v;
		if (sel[0])
			v[7:0] = wdata[7:0];
		if (sel[1])
			v[15:8] = wdata[15:8];
		return v;
	endfunction

	always_comb begin
		rsp_o.request_output = hit & (req_i.we | req_i.oe);
		rsp_o.data_read      = '0;
		if (offset == `PWM_REG_EN)
			rsp_o.data_read = 32'(en_q);
		else if (offset == `PWM_REG_PERIOD)
			rsp_o.data_read = 32'(period_q);
		for (int c = 0; c < CH; c++) begin
			if (offset == `PWM_REG_DUTY0 + 14'(c))
				rsp_o.data_read = 32'(duty_q[c]);
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			period_q <= '0;
			en_q     <= '0;
			for (int c = 0; c < CH; c++)
				duty_q[c] <= '0;
		end else if (wr_en) begin
			if (offset == `PWM_REG_EN && req_i.byte_select[0])
				en_q <= req_i.data_write[CH-1:0];
			if (offset == `PWM_REG_PERIOD)
				period_q <= merge16(period_q, req_i.data_write, req_i.byte_select);
			for (int c = 0; c < CH; c++) begin
				if (offset == `PWM_REG_DUTY0 + 14'(c))
					duty_q[c] <= merge16(duty_q[c], req_i.data_write, req_i.byte_select);
			end
		end
	end

	// Restart on a period write so the count stays in range
	always_ff @(posedge wb_clk_i) begin
		if (rst_i)
			cnt_q <= '0;
		else if (wr_en && offset == `PWM_REG_PERIOD)
			cnt_q <= '0;
		else if (cnt_q >= period_q)
			cnt_q <= '0;   // Wrap, one PWM cycle is period+1 clocks
		else
			cnt_q <= cnt_q + 16'd1;
	end

	always_comb begin
		for (int c = 0; c < CH; c++)
			pwm_out_o[c] = en_q[c] & (cnt_q < duty_q[c]);
	end

	cnt_in_range: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		cnt_q <= period_q);

endmodule

`default_nettype wire

// ==== periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_top (
	input  wire                         wb_clk_i,
	input  wire                         rst_i,
	input  wire                         wb_cyc_i,
	input  wire                         wb_stb_i,
	input  wire                         wb_we_i,
	input  wire [3:0]                   wb_sel_i,
	input  wire [23:0]                  wb_adr_i,
	input  wire [31:0]                  wb_data_i,
	output wire                         wb_ack_o,
	output wire                         wb_error_o,
	output wire                         wb_stall_o,
	output wire [31:0]                  wb_data_o,
	input  wire [`PERIPH_IO_PADS-1:0]   io_in_i,
	output wire [`PERIPH_IO_PADS-1:0]   io_out_o,
	output wire [`PERIPH_IO_PADS-1:0]   io_oeb_o
);

	periph_pkg::periph_req_t periph_req;
	periph_pkg::periph_rsp_t gpio_rsp;
	periph_pkg::periph_rsp_t pwm_rsp;
	periph_pkg::periph_rsp_t iomux_rsp;

	wire [`PERIPH_IO_PADS-1:0]      gpio_input;
	wire [`PERIPH_IO_PADS-1:0]      gpio_output;
	wire [`PERIPH_IO_PADS-1:0]      gpio_oe;
	wire [`PERIPH_PWM_CHANNELS-1:0] pwm_out;

	wb_periph_bridge u_bridge (
		.wb_clk_i    (wb_clk_i),
		.rst_i       (rst_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_sel_i    (wb_sel_i),
		.wb_adr_i    (wb_adr_i),
		.wb_data_i   (wb_data_i),
		.wb_ack_o    (wb_ack_o),
		.wb_error_o  (wb_error_o),
		.wb_stall_o  (wb_stall_o),
		.wb_data_o   (wb_data_o),
		.req_o       (periph_req),
		.pwm_rsp_i   (pwm_rsp),
		.gpio_rsp_i  (gpio_rsp),
		.iomux_rsp_i (iomux_rsp)
	);

	periph_gpio u_gpio (
		.wb_clk_i      (wb_clk_i),
		.rst_i         (rst_i),
		.req_i         (periph_req),
		.gpio_input_i  (gpio_input),
		.rsp_o         (gpio_rsp),
		.gpio_output_o (gpio_output),
		.gpio_oe_o     (gpio_oe)
	);

	periph_pwm u_pwm (
		.wb_clk_i  (wb_clk_i),
		.rst_i     (rst_i),
		.req_i     (periph_req),
		.rsp_o     (pwm_rsp),
		.pwm_out_o (pwm_out)
	);

	periph_io_mux u_io_mux (
		.wb_clk_i      (wb_clk_i),
		.rst_i         (rst_i),
		.req_i         (periph_req),
		.gpio_output_i (gpio_output),
		.gpio_oe_i     (gpio_oe),
		.pwm_out_i     (pwm_out),
		.io_in_i       (io_in_i),
		.rsp_o         (iomux_rsp),
		.gpio_input_o  (gpio_input),
		.io_out_o      (io_out_o),
		.io_oeb_o      (io_oeb_o)
	);

endmodule

`default_nettype wire

// ==== tb_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module tb_periph_top;

	localparam int TEST_COUNT  = 6;
	localparam int TEST_ITERS  = 12;
	localparam int MAX_PERIOD  = 67;
	localparam int WINDOW      = 4 * (MAX_PERIOD + 1);   // Longest PWM measurement
	localparam int WATCHDOG    = TEST_COUNT * TEST_ITERS * WINDOW + 416;
	localparam int BUS_TIMEOUT = 16;
	localparam int STIM_DELAY  = 1;

	logic                       wb_clk_i = 1'b0;
	logic                       rst_i;
	logic                       wb_cyc_i;
	logic                       wb_stb_i;
	logic                       wb_we_i;
	logic [3:0]                 wb_sel_i;
	logic [23:0]                wb_adr_i;
	logic [31:0]                wb_data_i;
	wire                        wb_ack_o;
	wire                        wb_error_o;
	wire                        wb_stall_o;
	wire [31:0]                 wb_data_o;
	logic [`PERIPH_IO_PADS-1:0] io_in_i;
	wire [`PERIPH_IO_PADS-1:0]  io_out_o;
	wire [`PERIPH_IO_PADS-1:0]  io_oeb_o;

	int                         seed;
	string                      test_name = "reset";
	logic [`PERIPH_IO_PADS-1:0] model_out = '0;
	logic [`PERIPH_IO_PADS-1:0] model_oe = '0;
	logic [`PERIPH_IO_PADS-1:0] model_sel = '0;   // 1 means the pad belongs to PWM
	logic                       accept_d1 = 1'b0;
	logic                       accept_d2 = 1'b0;
	wire                        bus_accept = wb_cyc_i & wb_stb_i & ~wb_stall_o;

	periph_top dut (.*);

	always #4 wb_clk_i = ~wb_clk_i;

	always @(posedge wb_clk_i) begin
		accept_d1 <= bus_accept;
		accept_d2 <= accept_d1;
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else report_mismatch(name, expected, actual);
	endtask

	ack_error_exclusive: assert property (@(posedge wb_clk_i) !(wb_ack_o && wb_error_o))
		else report_mismatch({test_name, " ack and error"}, 32'd0, 32'(wb_ack_o & wb_error_o));

	// Ack or error exactly two edges after the strobe is taken
	response_two_cycles: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(wb_ack_o || wb_error_o) == accept_d2)
		else report_mismatch({test_name, " response timing"}, 32'(accept_d2),
			32'(wb_ack_o | wb_error_o));

	stall_while_busy: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		accept_d1 |-> (wb_stall_o && !wb_ack_o && !wb_error_o))
		else report_error({test_name, ": stall dropped or early response during an access"});

	idle_after_reset: assert property (@(posedge wb_clk_i)
		$past(rst_i) |-> !(wb_ack_o || wb_error_o || wb_stall_o))
		else report_error("Bridge not idle right after reset");

	gpio_pad_out: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(io_out_o & ~model_sel) == (model_out & ~model_sel))
		else report_mismatch({test_name, " gpio pad out"}, 32'(model_out & ~model_sel),
			32'(io_out_o & ~model_sel));

	gpio_pad_oeb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(io_oeb_o & ~model_sel) == (~model_oe & ~model_sel))
		else report_mismatch({test_name, " gpio pad oeb"}, 32'(~model_oe & ~model_sel),
			32'(io_oeb_o & ~model_sel));

	pwm_pad_oeb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(io_oeb_o & model_sel) == '0)
		else report_mismatch({test_name, " pwm pad oeb"}, 32'd0, 32'(io_oeb_o & model_sel));

	function automatic logic [23:0] reg_addr(input logic [7:0] id, input logic [13:0] offset);
		return {id, offset, 2'b00};
	endfunction

	// Selected bytes take the new data, the rest keep the old value
	function automatic logic [15:0] merge_bytes(input logic [15:0] old_v,
			input logic [31:0] data, input logic [3:0] sel);
		logic [15:0] mask;
		mask = {{8{sel[1]}}, {8{sel[0]}}};
		return (old_v & ~mask) | (data[15:0] & mask);
	endfunction

	task automatic next_drive();
		@(posedge wb_clk_i);
		#STIM_DELAY;
	endtask

	task automatic bus_cycle(input logic we, input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
		int waited;
		next_drive();
		wb_cyc_i  = 1'b1;
		wb_stb_i  = 1'b1;
		wb_we_i   = we;
		wb_sel_i  = sel;
		wb_adr_i  = adr;
		wb_data_i = wdata;
		waited    = 0;
		@(negedge wb_clk_i);
		while (wb_stall_o) begin
			waited++;
			if (waited > BUS_TIMEOUT)
				report_error({test_name, ": bridge never accepted the strobe"});
			@(negedge wb_clk_i);
		end
		next_drive();   // Strobe was taken at this edge
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		waited   = 0;
		while (!(wb_ack_o || wb_error_o)) begin
			@(negedge wb_clk_i);
			waited++;
			if (waited > BUS_TIMEOUT)
				report_error({test_name, ": no ack or error from the bridge"});
		end
		check_value({test_name, " latency"}, 32'd2, 32'(waited));
		check_value({test_name, " error flag"}, 32'(exp_err), 32'(wb_error_o));
		rdata = wb_data_o;
	endtask

	task automatic wb_write(input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] wdata, input logic exp_err);
		logic [31:0] unused_rd;
		bus_cycle(1'b1, adr, sel, wdata, exp_err, unused_rd);
	endtask

	task automatic wb_read(input logic [23:0] adr, input logic exp_err,
			output logic [31:0] rdata);
		bus_cycle(1'b0, adr, 4'hf, 32'd0, exp_err, rdata);
	endtask

	task automatic count_pad_high(input int pad, input int cycles, output int highs);
		highs = 0;
		repeat (cycles) begin
			@(negedge wb_clk_i);
			highs += int'(io_out_o[pad]);
		end
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [3:0]  sel;
		logic [13:0] offset;
		logic [15:0] period;
		logic [15:0] duty;
		logic [15:0] sel_val;
		int          ch;
		int          pad;
		int          highs;
		seed      = 32'hdd0a_84ec;
		rst_i     = 1'b1;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_sel_i  = 4'h0;
		wb_adr_i  = '0;
		wb_data_i = '0;
		io_in_i   = '0;
		repeat (3) @(posedge wb_clk_i);
		#STIM_DELAY;
		rst_i = 1'b0;

		test_name = "gpio_byte_select";
		for (int i = 0; i < TEST_ITERS; i++) begin
			wdata  = $random(seed);
			sel    = 4'($random(seed));
			offset = (i % 2 == 0) ? `GPIO_REG_OUT : `GPIO_REG_OE;
			wb_write(reg_addr(`PERIPH_ID_GPIO, offset), sel, wdata, 1'b0);
			if (i % 2 == 0)
				model_out = merge_bytes(model_out, wdata, sel);
			else
				model_oe = merge_bytes(model_oe, wdata, sel);
			wb_read(reg_addr(`PERIPH_ID_GPIO, offset), 1'b0, rdata);
			check_value(test_name, (i % 2 == 0) ? 32'(model_out) : 32'(model_oe), rdata);
		end

		test_name = "unmapped_id";
		wdata = $random(seed);
		wb_write(reg_addr(8'h7f, `GPIO_REG_OUT), 4'hf, wdata, 1'b1);
		wb_write(reg_addr(8'h7f, `GPIO_REG_OE), 4'hf, ~wdata, 1'b1);
		wb_read(reg_addr(8'h7f, 14'd0), 1'b1, rdata);
		check_value(test_name, 32'hffff_ffff, rdata);
		wb_read(reg_addr(`PERIPH_ID_GPIO, `GPIO_REG_OUT), 1'b0, rdata);
		check_value(test_name, 32'(model_out), rdata);
		wb_read(reg_addr(`PERIPH_ID_GPIO, `GPIO_REG_OE), 1'b0, rdata);
		check_value(test_name, 32'(model_oe), rdata);

		test_name = "gpio_input";
		for (int i = 0; i < TEST_ITERS; i++) begin
			next_drive();
			io_in_i = `PERIPH_IO_PADS'($random(seed));
			repeat (3) next_drive();   // Let the synchronizer settle
			wb_read(reg_addr(`PERIPH_ID_GPIO, `GPIO_REG_IN), 1'b0, rdata);
			check_value(test_name, 32'(io_in_i), rdata);
		end

		test_name = "pwm_pad";
		for (int i = 0; i < TEST_ITERS; i++) begin
			period  = 16'd4 + 16'($random(seed) & 63);
			duty    = 16'($unsigned($random(seed)) % (32'(period) + 32'd1));
			ch      = int'($unsigned($random(seed)) % 4);
			pad     = ch + 4 * int'($unsigned($random(seed)) % 4);
			sel_val = 16'($random(seed)) | (16'd1 << pad);
			wb_write(reg_addr(`PERIPH_ID_IOMUX, `IOMUX_REG_SEL), 4'hf, 32'(sel_val), 1'b0);
			model_sel = sel_val;
			wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_PERIOD), 4'hf, 32'(period), 1'b0);
			wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_DUTY0 + 14'(ch)), 4'hf, 32'(duty), 1'b0);
			wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_EN), 4'hf, 32'd1 << ch, 1'b0);
			repeat (2) begin
				count_pad_high(pad, int'(period) + 1, highs);
				check_value(test_name, 32'(duty), 32'(highs));
			end
			wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_EN), 4'hf, 32'd0, 1'b0);
			count_pad_high(pad, int'(period) + 1, highs);
			check_value({test_name, " disabled"}, 32'd0, 32'(highs));
		end

		test_name = "register_readback";
		sel_val = 16'($random(seed));
		wb_write(reg_addr(`PERIPH_ID_IOMUX, `IOMUX_REG_SEL), 4'hf, 32'(sel_val), 1'b0);
		model_sel = sel_val;
		wb_read(reg_addr(`PERIPH_ID_IOMUX, `IOMUX_REG_SEL), 1'b0, rdata);
		check_value(test_name, 32'(sel_val), rdata);
		wdata = $random(seed);
		wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_EN), 4'h1, wdata, 1'b0);
		wb_read(reg_addr(`PERIPH_ID_PWM, `PWM_REG_EN), 1'b0, rdata);
		check_value(test_name, 32'(wdata[`PERIPH_PWM_CHANNELS-1:0]), rdata);
		wdata = $random(seed);
		wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_PERIOD), 4'hf, wdata, 1'b0);
		wb_read(reg_addr(`PERIPH_ID_PWM, `PWM_REG_PERIOD), 1'b0, rdata);
		check_value(test_name, 32'(wdata[15:0]), rdata);
		for (int c = 0; c < `PERIPH_PWM_CHANNELS; c++) begin
			wdata = $random(seed);
			wb_write(reg_addr(`PERIPH_ID_PWM, `PWM_REG_DUTY0 + 14'(c)), 4'hf, wdata, 1'b0);
			wb_read(reg_addr(`PERIPH_ID_PWM, `PWM_REG_DUTY0 + 14'(c)), 1'b0, rdata);
			check_value(test_name, 32'(wdata[15:0]), rdata);
		end

		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge wb_clk_i);
		report_error("Watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// ==== wb_periph_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_periph_bridge (
	input  wire                     wb_clk_i,
	input  wire                     rst_i,
	input  wire                     wb_cyc_i,
	input  wire                     wb_stb_i,
	input  wire                     wb_we_i,
	input  wire [3:0]               wb_sel_i,
	input  wire [23:0]              wb_adr_i,
	input  wire [31:0]              wb_data_i,
	output logic                    wb_ack_o,
	output logic                    wb_error_o,
	output logic                    wb_stall_o,
	output logic [31:0]             wb_data_o,
	output periph_pkg::periph_req_t req_o,
	input  wire periph_pkg::periph_rsp_t pwm_rsp_i,
	input  wire periph_pkg::periph_rsp_t gpio_rsp_i,
	input  wire periph_pkg::periph_rsp_t iomux_rsp_i
);

	typedef enum logic {ST_IDLE, ST_BUSY} state_t;

	state_t      state_q;
	logic        we_q;
	logic        oe_q;
	logic [23:0] addr_q;
	logic [3:0]  sel_q;
	logic [31:0] wdata_q;
	logic        accept;
	logic        claimed;
	logic [31:0] rd_data;

	// Ack cycle also counts as stalled so a held strobe is not taken twice
	assign wb_stall_o = (state_q == ST_BUSY) | wb_ack_o | wb_error_o;
	assign accept     = wb_cyc_i & wb_stb_i & ~wb_stall_o;

	always_comb begin
		req_o.we          = we_q;
		req_o.oe          = oe_q;
		req_o.address     = addr_q;
		req_o.byte_select = sel_q;
		req_o.data_write  = wdata_q;
	end

	// Priority PWM, GPIO, IO mux
	always_comb begin
		claimed = 1'b1;
		rd_data = '1;
		if (pwm_rsp_i.request_output)
			rd_data = pwm_rsp_i.data_read;
		else if (gpio_rsp_i.request_output)
			rd_data = gpio_rsp_i.data_read;
		else if (iomux_rsp_i.request_output)
			rd_data = iomux_rsp_i.data_read;
		else
			claimed = 1'b0;   // Nobody home, answer with error
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			state_q    <= ST_IDLE;
			we_q       <= 1'b0;
			oe_q       <= 1'b0;
			wb_ack_o   <= 1'b0;
			wb_error_o <= 1'b0;
		end else begin
			wb_ack_o   <= 1'b0;
			wb_error_o <= 1'b0;
			case (state_q)
				ST_IDLE: if (accept) begin
					state_q <= ST_BUSY;
					we_q    <= wb_we_i;
					oe_q    <= ~wb_we_i;
				end
				ST_BUSY: begin
					state_q    <= ST_IDLE;
					we_q       <= 1'b0;
					oe_q       <= 1'b0;
					wb_ack_o   <= claimed;
					wb_error_o <= ~claimed;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			addr_q  <= wb_adr_i;
			sel_q   <= wb_sel_i;
			wdata_q <= wb_data_i;
		end
		if (state_q == ST_BUSY)
			wb_data_o <= rd_data;
	end

	ack_err_exclusive: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		!(wb_ack_o && wb_error_o));

	ack_after_request: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		wb_ack_o |-> $past(req_o.we || req_o.oe));

endmodule

`default_nettype wire
